// File: filelist.f
+incdir+src
src/bdCorePkg.sv
src/bdDecoder.sv
src/bdTagSplit.sv
src/spikeFilter.sv
src/timeMgr.sv
src/pcPacker.sv
src/bdUpCore.sv
verification/bdUpCoreTb.sv

// File: src/bdCorePkg.sv
`include "bdCore_macros.svh"

package bdCorePkg;

  // Raw chip word, leaf prefix still attached
  typedef logic [`BD_N_WORD-1:0] bdWord_t;

  // Leaf index 0..3 from the prefix
  typedef logic [1:0] leafCode_t;

  // Word with prefix removed, zero-padded on top
  typedef logic [`BD_N_WORD-2:0] payload_t;

  // Fields of a leaf 0 word
  typedef logic [`BD_N_TAG-1:0] tag_t;
  typedef logic [`BD_N_CT-1:0] count_t;
  typedef logic [`BD_N_GLOBAL-1:0] globalRoute_t;

  // Filter accumulator and its index
  typedef logic [`BD_N_FSTATE-1:0] filterState_t;
  typedef logic [$clog2(`BD_N_FILTS)-1:0] filterId_t;

  // Code in the top byte, data below
  typedef logic [`PC_N_CODE+`PC_N_DATA-1:0] pcWord_t;

  // Spike filter FSM
  typedef enum logic {
    SF_IDLE,
    SF_REPORT
  } sfState_t;

endpackage

// File: src/bdCore_macros.svh
`ifndef BDCORE_MACROS_SVH
`define BDCORE_MACROS_SVH

// Chip side word layout
`define BD_N_WORD 34
`define BD_N_TAG 11
`define BD_N_CT 9
`define BD_N_GLOBAL 12

// PC side word layout
`define PC_N_CODE 8
`define PC_N_DATA 24

// Spike filter bank
`define BD_N_FILTS 8
`define BD_N_FSTATE 16

// Time unit counter width
`define BD_N_UNIT 16

// PC codes for words built in the FPGA
`define PC_CODE_GLOBAL 8'h04
// Report base, filter id goes in the low bits
`define PC_CODE_REPORT 8'h10

`endif

// File: src/bdDecoder.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module bdDecoder (
  input  logic                 clk,
  input  logic                 rst,
  input  bdCorePkg::bdWord_t   bdInData,
  input  logic                 bdInValid,
  output logic                 bdInAck,
  output bdCorePkg::leafCode_t decLeaf,
  output bdCorePkg::payload_t  decPayload,
  output logic                 decValid,
  input  logic                 decAck
);
  import bdCorePkg::*;

  localparam int msb = `BD_N_WORD - 1;

  leafCode_t nextLeaf;
  payload_t  nextPayload;
  logic      inXfer;

  // Take a word when the stage is empty or draining this cycle
  assign bdInAck = !decValid || decAck;
  assign inXfer  = bdInValid && bdInAck;

  // Priority decode from the top bit down
  always_comb begin
    if (bdInData[msb]) begin
      nextLeaf    = 2'd0;
      nextPayload = bdInData[msb-1:0];
    end else if (bdInData[msb-1]) begin
      nextLeaf    = 2'd1;
      nextPayload = {1'b0, bdInData[msb-2:0]};
    end else if (bdInData[msb-2]) begin
      nextLeaf    = 2'd2;
      nextPayload = {2'b00, bdInData[msb-3:0]};
    end else begin
      // 000 prefix, same payload width as leaf 2
      nextLeaf    = 2'd3;
      nextPayload = {2'b00, bdInData[msb-3:0]};
    end
  end

  // Stage valid
  always_ff @(posedge clk) begin
    if (rst) begin
      decValid <= 1'b0;
    end else if (bdInAck) begin
      decValid <= bdInValid;
    end
  end

  // Leaf and payload
  always_ff @(posedge clk) begin
    if (inXfer) begin
      decLeaf    <= nextLeaf;
      decPayload <= nextPayload;
    end
  end

  // Output word stays put until the split stage takes it
  assert property (@(posedge clk) disable iff (rst)
    decValid && !decAck |=> decValid && $stable(decPayload) && $stable(decLeaf));

endmodule

// File: src/bdTagSplit.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module bdTagSplit (
  input  logic                 clk,
  input  logic                 rst,
  input  bdCorePkg::leafCode_t decLeaf,
  input  bdCorePkg::payload_t  decPayload,
  input  logic                 decValid,
  output logic                 decAck,
  output bdCorePkg::tag_t      tsTag,
  output bdCorePkg::count_t    tsCount,
  output logic                 tsValid,
  input  logic                 tsAck,
  output bdCorePkg::leafCode_t osLeaf,
  output bdCorePkg::payload_t  osPayload,
  output logic                 osValid,
  input  logic                 osAck
);
  import bdCorePkg::*;

  // Leaf 0 field positions
  localparam int tagLo    = `BD_N_CT;
  localparam int globalLo = `BD_N_CT + `BD_N_TAG;
  localparam int globalHi = globalLo + `BD_N_GLOBAL - 1;

  globalRoute_t globalField;
  logic         isLocal;
  logic         tsRoom;
  logic         osRoom;
  logic         take;

  assign globalField = decPayload[globalHi:globalLo];
  // Local spike tag is leaf 0 with no global route
  assign isLocal = (decLeaf == 2'd0) && (globalField == '0);

  // Each output register is free when empty or draining
  assign tsRoom = !tsValid || tsAck;
  assign osRoom = !osValid || osAck;

  // Ack only if the chosen destination can take it
  assign decAck = isLocal ? tsRoom : osRoom;
  assign take   = decValid && decAck;

  always_ff @(posedge clk) begin
    if (rst) begin
      tsValid <= 1'b0;
      osValid <= 1'b0;
    end else begin
      if (tsRoom) begin
        tsValid <= take && isLocal;
      end
      if (osRoom) begin
        osValid <= take && !isLocal;
      end
    end
  end

  // Tag stream fields
  always_ff @(posedge clk) begin
    if (take && isLocal) begin
      tsTag   <= decPayload[globalLo-1:tagLo];
      tsCount <= decPayload[tagLo-1:0];
    end
  end

  // Everything else passes whole
  always_ff @(posedge clk) begin
    if (take && !isLocal) begin
      osLeaf    <= decLeaf;
      osPayload <= decPayload;
    end
  end

  // Stalled words hold until the consumer takes them
  assert property (@(posedge clk) disable iff (rst)
    tsValid && !tsAck |=> tsValid && $stable(tsTag) && $stable(tsCount));
  assert property (@(posedge clk) disable iff (rst)
    osValid && !osAck |=> osValid && $stable(osLeaf) && $stable(osPayload));

endmodule

// File: src/bdUpCore.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module bdUpCore (
  input  logic                  clk,
  input  logic                  rst,
  input  bdCorePkg::bdWord_t    bdInData,
  input  logic                  bdInValid,
  output logic                  bdInAck,
  input  logic [`BD_N_UNIT-1:0] unitLen,
  output bdCorePkg::pcWord_t    pcOutData,
  output logic                  pcOutValid,
  input  logic                  pcOutAck
);
  import bdCorePkg::*;

  //////////////////////////////////////////////////////////////////////////
  // Stage wiring
  //////////////////////////////////////////////////////////////////////////

  // Decoder to splitter
  leafCode_t    decLeaf;
  payload_t     decPayload;
  logic         decValid;
  logic         decAck;

  // Local tags to the filter bank
  tag_t         tsTag;
  count_t       tsCount;
  logic         tsValid;
  logic         tsAck;

  // Non-local words to the packer
  leafCode_t    osLeaf;
  payload_t     osPayload;
  logic         osValid;
  logic         osAck;

  // Filter reports to the packer
  filterId_t    rpId;
  filterState_t rpState;
  logic         rpValid;
  logic         rpAck;

  // Time base
  logic                  unitPulse;
  logic [`BD_N_UNIT-1:0] unitsElapsed;

  bdDecoder decoder_i (
    .clk(clk), .rst(rst),
    .bdInData(bdInData), .bdInValid(bdInValid), .bdInAck(bdInAck),
    .decLeaf(decLeaf), .decPayload(decPayload), .decValid(decValid), .decAck(decAck)
  );

  bdTagSplit tagSplit_i (
    .clk(clk), .rst(rst),
    .decLeaf(decLeaf), .decPayload(decPayload), .decValid(decValid), .decAck(decAck),
    .tsTag(tsTag), .tsCount(tsCount), .tsValid(tsValid), .tsAck(tsAck),
    .osLeaf(osLeaf), .osPayload(osPayload), .osValid(osValid), .osAck(osAck)
  );

  spikeFilter #(.nFilts(`BD_N_FILTS)) filter_i (
    .clk(clk), .rst(rst), .unitPulse(unitPulse),
    .tsTag(tsTag), .tsCount(tsCount), .tsValid(tsValid), .tsAck(tsAck),
    .rpId(rpId), .rpState(rpState), .rpValid(rpValid), .rpAck(rpAck)
  );

  // Elapsed count kept for later heartbeat use
  timeMgr timeMgr_i (
    .clk(clk), .rst(rst), .unitLen(unitLen),
    .unitPulse(unitPulse), .unitsElapsed(unitsElapsed)
  );

  pcPacker packer_i (
    .clk(clk), .rst(rst),
    .osLeaf(osLeaf), .osPayload(osPayload), .osValid(osValid), .osAck(osAck),
    .rpId(rpId), .rpState(rpState), .rpValid(rpValid), .rpAck(rpAck),
    .pcOutData(pcOutData), .pcOutValid(pcOutValid), .pcOutAck(pcOutAck)
  );

endmodule

// File: src/pcPacker.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module pcPacker (
  input  logic                    clk,
  input  logic                    rst,
  input  bdCorePkg::leafCode_t    osLeaf,
  input  bdCorePkg::payload_t     osPayload,
  input  logic                    osValid,
  output logic                    osAck,
  input  bdCorePkg::filterId_t    rpId,
  input  bdCorePkg::filterState_t rpState,
  input  logic                    rpValid,
  output logic                    rpAck,
  output bdCorePkg::pcWord_t      pcOutData,
  output logic                    pcOutValid,
  input  logic                    pcOutAck
);
  import bdCorePkg::*;

  // Global and tag sit together in payload bits 31:9
  localparam int routeLo = `BD_N_CT;
  localparam int routeHi = `BD_N_CT + `BD_N_TAG + `BD_N_GLOBAL - 1;
  localparam int routePad = `PC_N_DATA - (routeHi - routeLo + 1);
  localparam int idPad = `PC_N_CODE - $bits(filterId_t);

  logic                  outFree;
  logic [`PC_N_CODE-1:0] osCode;
  logic [`PC_N_DATA-1:0] osData;
  logic [`PC_N_CODE-1:0] rpCode;
  logic [`PC_N_DATA-1:0] rpData;
  pcWord_t               nextWord;

  assign outFree = !pcOutValid || pcOutAck;

  // Other stream has priority
  assign osAck = outFree;
  assign rpAck = outFree && !osValid;

  //////////////////////////////////////////////////////////////////////////
  // Word formats
  //////////////////////////////////////////////////////////////////////////
  always_comb begin
    if (osLeaf == 2'd0) begin
      // Global route word
      osCode = `PC_CODE_GLOBAL;
      osData = {{routePad{1'b0}}, osPayload[routeHi:routeLo]};
    end else begin
      osCode = {{(`PC_N_CODE-2){1'b0}}, osLeaf};
      osData = osPayload[`PC_N_DATA-1:0];
    end
  end

  // Filter id goes into the low code bits
  assign rpCode = `PC_CODE_REPORT | {{idPad{1'b0}}, rpId};
  assign rpData = {{(`PC_N_DATA-`BD_N_FSTATE){1'b0}}, rpState};

  assign nextWord = osValid ? {osCode, osData} : {rpCode, rpData};

  always_ff @(posedge clk) begin
    if (rst) begin
      pcOutValid <= 1'b0;
    end else if (outFree) begin
      pcOutValid <= osValid || rpValid;
    end
  end

  // Output word
  always_ff @(posedge clk) begin
    if (outFree && (osValid || rpValid)) begin
      pcOutData <= nextWord;
    end
  end

  // Stalled word held for the host
  assert property (@(posedge clk) disable iff (rst)
    pcOutValid && !pcOutAck |=> pcOutValid && $stable(pcOutData));

endmodule

// File: src/spikeFilter.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module spikeFilter #(
  parameter int nFilts = `BD_N_FILTS
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    unitPulse,
  input  bdCorePkg::tag_t         tsTag,
  input  bdCorePkg::count_t       tsCount,
  input  logic                    tsValid,
  output logic                    tsAck,
  output bdCorePkg::filterId_t    rpId,
  output bdCorePkg::filterState_t rpState,
  output logic                    rpValid,
  input  logic                    rpAck
);
  import bdCorePkg::*;

  localparam filterId_t lastId = filterId_t'(nFilts - 1);
  localparam filterState_t stateMax = '1;

  sfState_t                state;
  filterState_t            acc [nFilts];
  filterId_t               scanIdx;
  filterId_t               tagIdx;
  logic                    tagHit;
  logic [`BD_N_FSTATE:0]   sum;
  filterState_t            satSum;
  logic                    outFree;
  logic                    emit;

  // Tags accepted only between reports
  assign tsAck = (state == SF_IDLE);

  // Tags past the bank are dropped
  assign tagIdx = tsTag[$bits(filterId_t)-1:0];
  assign tagHit = tsTag < nFilts;

  // Saturating add
  assign sum    = {1'b0, acc[tagIdx]} + tsCount;
  assign satSum = sum[`BD_N_FSTATE] ? stateMax : sum[`BD_N_FSTATE-1:0];

  // Report register free, and a nonzero filter under the scan
  assign outFree = !rpValid || rpAck;
  assign emit    = (state == SF_REPORT) && outFree && (acc[scanIdx] != '0);

  //////////////////////////////////////////////////////////////////////////
  // FSM, accumulators, report valid
  //////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= SF_IDLE;
      scanIdx <= '0;
      rpValid <= 1'b0;
      for (int i = 0; i < nFilts; i++) begin
        acc[i] <= '0;
      end
    end else begin
      if (emit) begin
        rpValid <= 1'b1;
      end else if (rpAck) begin
        rpValid <= 1'b0;
      end
      case (state)
        SF_IDLE: begin
          if (tsValid && tsAck && tagHit) begin
            acc[tagIdx] <= satSum;
          end
          // Scan restarts at filter 0
          if (unitPulse) begin
            state   <= SF_REPORT;
            scanIdx <= '0;
          end
        end
        SF_REPORT: begin
          // Walk one filter per free report slot
          if (outFree) begin
            if (emit) begin
              acc[scanIdx] <= '0;
            end
            if (scanIdx == lastId) begin
              state <= SF_IDLE;
            end else begin
              scanIdx <= scanIdx + 1'b1;
            end
          end
        end
        default: state <= SF_IDLE;
      endcase
    end
  end

  // Report fields
  always_ff @(posedge clk) begin
    if (emit) begin
      rpId    <= scanIdx;
      rpState <= acc[scanIdx];
    end
  end

  // Only real, nonempty filters get reported
  assert property (@(posedge clk) disable iff (rst)
    rpValid |-> (rpId < nFilts) && (rpState != '0));

endmodule

// File: src/timeMgr.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module timeMgr (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`BD_N_UNIT-1:0] unitLen,
  output logic                  unitPulse,
  output logic [`BD_N_UNIT-1:0] unitsElapsed
);

  logic [`BD_N_UNIT-1:0] cycleCount;
  logic                  lastCycle;

  // Zero length means no pulses
  assign lastCycle = (unitLen != '0) && (cycleCount == unitLen - 1'b1);

  // Pulse lands one cycle after the wrap point
  always_ff @(posedge clk) begin
    if (rst) begin
      cycleCount   <= '0;
      unitPulse    <= 1'b0;
      unitsElapsed <= '0;
    end else begin
      unitPulse <= lastCycle;
      if (lastCycle || unitLen == '0) begin
        cycleCount <= '0;
      end else begin
        cycleCount <= cycleCount + 1'b1;
      end
      if (lastCycle) begin
        unitsElapsed <= unitsElapsed + 1'b1;
      end
    end
  end

endmodule

// File: verification/bdUpCoreTb.sv
`timescale 1ns/1ns
`include "bdCore_macros.svh"

module bdUpCoreTb;
  import bdCorePkg::*;

  localparam logic [`BD_N_UNIT-1:0] unitCycles = 16'd40;

  logic                  clk = 1'b0;
  logic                  rst;
  bdWord_t               bdInData;
  logic                  bdInValid;
  logic                  bdInAck;
  logic [`BD_N_UNIT-1:0] unitLen;
  pcWord_t               pcOutData;
  logic                  pcOutValid;
  logic                  pcOutAck;

  // Golden stimulus and expectations
  bdWord_t inWords[$];
  pcWord_t expWords[$];
  int      expTotal[`BD_N_FILTS];
  int      gotTotal[`BD_N_FILTS];

  int          sendIdx = 0;
  int          outIdx = 0;
  int          cycleCount = 0;
  int          cycleLimit = 0;
  logic        inTaken = 1'b0;
  logic        drain = 1'b0;
  logic [31:0] lfsrState = 32'h93f0;

  bdUpCore dut_i (
    .clk(clk), .rst(rst),
    .bdInData(bdInData), .bdInValid(bdInValid), .bdInAck(bdInAck),
    .unitLen(unitLen),
    .pcOutData(pcOutData), .pcOutValid(pcOutValid), .pcOutAck(pcOutAck)
  );

  // 4 ns clock
  always #2 clk = ~clk;

  // Fibonacci taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit
  function automatic logic randomBit();
    lfsrState = lfsrNext(lfsrState);
    return lfsrState[0];
  endfunction

  task automatic failRun();
    $display("test failed");
    $fatal(1);
  endtask

  // A golden line must carry all of its fields
  task automatic expectFields(input int got, input int want);
    assert (got == want) else begin
      $display("golden file line holds %0d fields instead of %0d", got, want);
      failRun();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Golden file reader
  ////////////////////////////////////////////////////////////////////////////
  task automatic readGolden();
    int              fd;
    int              rc;
    int              id;
    logic [8*8-1:0]  kind;
    logic [8*128-1:0] restOfLine;
    logic [63:0]     value;
    fd = $fopen("verification/bdUpCore_golden.txt", "r");
    assert (fd != 0) else begin
      $display("could not open verification/bdUpCore_golden.txt");
      failRun();
    end
    while ($fscanf(fd, "%s", kind) == 1) begin
      if (kind == "#") begin
        rc = $fgets(restOfLine, fd);
      end else if (kind == "I") begin
        rc = $fscanf(fd, "%h", value);
        expectFields(rc, 1);
        inWords.push_back(value[`BD_N_WORD-1:0]);
      end else if (kind == "O") begin
        rc = $fscanf(fd, "%h", value);
        expectFields(rc, 1);
        expWords.push_back(value[31:0]);
      end else if (kind == "F") begin
        rc = $fscanf(fd, "%d %h", id, value);
        expectFields(rc, 2);
        expTotal[id] = value;
      end else begin
        $display("golden file holds a line of unknown kind");
        failRun();
      end
    end
    $fclose(fd);
  endtask

  // Ordered compare for data words and per-id sums for reports
  task automatic checkPcWord(input pcWord_t word);
    logic [`PC_N_CODE-1:0] code;
    logic [`PC_N_DATA-1:0] data;
    int                    id;
    code = word[`PC_N_CODE+`PC_N_DATA-1:`PC_N_DATA];
    data = word[`PC_N_DATA-1:0];
    id   = code & 8'h0f;
    if ((code & 8'hf0) == `PC_CODE_REPORT) begin
      assert (id < `BD_N_FILTS) else begin
        $display("ERR pcOutData report code expected below %h got %h",
                 `PC_CODE_REPORT | `BD_N_FILTS, code);
        failRun();
      end
      assert (data != '0 && data < (1 << `BD_N_FSTATE)) else begin
        $display("ERR pcOutData report count expected nonzero 16-bit got %h", data);
        failRun();
      end
      gotTotal[id] += data;
    end else begin
      assert (outIdx < expWords.size()) else begin
        $display("extra output word %h after all expected words", word);
        failRun();
      end
      assert (word == expWords[outIdx]) else begin
        $display("ERR pcOutData expected %h got %h", expWords[outIdx], word);
        failRun();
      end
      outIdx++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus, back-pressure and timeout
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!rst) begin
      // New word only once the held one was taken
      if (!bdInValid || inTaken) begin
        if (sendIdx < inWords.size() && randomBit()) begin
          bdInData  <= inWords[sendIdx];
          bdInValid <= 1'b1;
          sendIdx++;
        end else begin
          bdInValid <= 1'b0;
        end
      end
      pcOutAck <= drain ? 1'b1 : randomBit();
      cycleCount++;
      assert (cycleCount < cycleLimit) else begin
        $display("timeout after %0d cycles, outputs did not drain (%0d of %0d words seen)",
                 cycleCount, outIdx, expWords.size());
        failRun();
      end
    end
  end

  // Handshakes sampled mid-cycle where they are settled
  always @(negedge clk) begin
    inTaken = bdInValid && bdInAck;
    if (!rst && pcOutValid && pcOutAck) begin
      checkPcWord(pcOutData);
    end
  end

  initial begin
    rst       = 1'b1;
    bdInData  = '0;
    bdInValid = 1'b0;
    pcOutAck  = 1'b0;
    unitLen   = unitCycles;
    for (int i = 0; i < `BD_N_FILTS; i++) begin
      expTotal[i] = 0;
      gotTotal[i] = 0;
    end
    readGolden();
    cycleLimit = inWords.size() * 64 + 2000;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    // Every word sent and every non-report word back
    while (sendIdx < inWords.size() || bdInValid || outIdx < expWords.size()) begin
      @(negedge clk);
    end
    // Let two unit pulses flush the filters
    drain = 1'b1;
    repeat (2 * unitCycles) @(posedge clk);
    for (int i = 0; i < `BD_N_FILTS; i++) begin
      assert (gotTotal[i] == expTotal[i]) else begin
        $display("ERR rpState total for filter %0d expected %h got %h",
                 i, expTotal[i], gotTotal[i]);
        failRun();
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

// File: verification/bdUpCore_golden.txt
# I  BD word to send, 34-bit hex    O  expected non-report PC word, 32-bit hex, in order
# F  filter id in decimal, then the expected sum of its report counts in hex
I 112ABCDEF
I 200000605
I 080345678
I 2000001FF
I 07FEDCBA9
I 212308A07
I 300000E20
I 200001033
I 2000FFE55
I 200000610
I 2FFFFFFFF
I 20000020A
I 200100000
O 01ABCDEF
O 02345678
O 03EDCBA9
O 04091845
O 047FFFFF
O 04000800
F 0 01FF
F 1 000A
F 2 0000
F 3 0015
F 4 0000
F 5 0000
F 6 0000
F 7 0020
